//--- rtl/adc_pkg.sv
`default_nettype none

package adc_pkg;

	////////////////////////////////////////
	// Lane and sample geometry
	////////////////////////////////////////

	localparam int N_LANES     = 5;  // D0[0], D0[1], D1[0], D1[1], FR
	localparam int LANE_BITS   = 8;  // Bits per deserialized lane word
	localparam int SAMPLE_BITS = 16; // One ADC conversion

	////////////////////////////////////////
	// SPI transfer
	////////////////////////////////////////

	// Write flag is 0 for a register write
	typedef struct packed {
		logic       rw;   // 0 write, 1 read
		logic [6:0] addr; // ADC register address
		logic [7:0] data; // Register contents
	} spi_word_t;

	localparam logic [7:0] CMD_SET_REG = 8'h31; // Host address high byte for reg write

	// Power-up configuration words
	localparam spi_word_t INIT_RESET_WORD  = 16'h0080; // Reg 0, software reset
	localparam spi_word_t INIT_FORMAT_WORD = 16'h0120; // Reg 1, two's complement
	localparam spi_word_t INIT_LANES_WORD  = 16'h0200; // Reg 2, two-lane output

	// Frame lane training pattern after 1:8 deserialization
	localparam logic [LANE_BITS-1:0] FRAME_PATTERN = 8'b10000111;

	////////////////////////////////////////
	// State encodings
	////////////////////////////////////////

	typedef enum logic [2:0] {
		WAIT_POWERUP, INIT_LOAD, INIT_SEND, IDLE, SET_LOAD, SET_SEND
	} cmd_state_t;

	typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_FINISH} spi_state_t;

	typedef enum logic {CHECK, SLIP} align_state_t;

endpackage

`default_nettype wire

//--- rtl/spi_master.sv
`timescale 1ns/10ps
`default_nettype none

module spi_master #(
	parameter int SPI_CLK_DIV = 4 // clk_in cycles per SCK half period
) (
	input  logic               clk_in,
	input  logic               rst_in,
	input  logic               spi_start,
	input  adc_pkg::spi_word_t spi_word,
	output logic               spi_ready,
	output logic               spi_scs,
	output logic               spi_sck,
	output logic               spi_sdo
);
	import adc_pkg::*;

	localparam int WORD_BITS = $bits(spi_word_t);
	localparam int BIT_W     = $clog2(WORD_BITS);
	localparam int DIV_W     = $clog2(SPI_CLK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_CLK_DIV - 1);
	localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(WORD_BITS - 1);

	spi_state_t           state;
	logic [DIV_W-1:0]     div_cnt;   // Half period divider
	logic [BIT_W-1:0]     bit_cnt;   // Bits already shifted out
	logic [WORD_BITS-1:0] shift_reg; // MSB drives SDO

	// Empties to zero after the last bit so SDO idles low
	assign spi_sdo = shift_reg[WORD_BITS-1];

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state     <= SPI_IDLE;
			div_cnt   <= '0;
			bit_cnt   <= '0;
			shift_reg <= '0;
			spi_ready <= 1'b1;
			spi_scs   <= 1'b1;
			spi_sck   <= 1'b0;
		end else begin
			case (state)
				SPI_IDLE: begin
					if (spi_start) begin
						shift_reg <= spi_word; // First bit valid as CS falls
						div_cnt   <= '0;
						bit_cnt   <= '0;
						spi_ready <= 1'b0;
						spi_scs   <= 1'b0;
						state     <= SPI_SHIFT;
					end
				end

				SPI_SHIFT: begin
					if (div_cnt == DIV_LAST) begin
						div_cnt <= '0;
						spi_sck <= ~spi_sck;
						// Falling SCK, move to next bit
						if (spi_sck) begin
							shift_reg <= {shift_reg[WORD_BITS-2:0], 1'b0};
							bit_cnt   <= bit_cnt + 1'b1;
							if (bit_cnt == BIT_LAST)
								state <= SPI_FINISH; // 32 half periods done
						end
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end

				SPI_FINISH: begin
					spi_scs   <= 1'b1; // Release CS
					spi_ready <= 1'b1;
					state     <= SPI_IDLE;
				end

				default: state <= SPI_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Handshake with the command controller
	////////////////////////////////////////

	a_start_when_ready: assert property (@(posedge clk_in) disable iff (rst_in)
		spi_start |-> spi_ready)
		else $error("SPI start while transfer in progress");

endmodule

`default_nettype wire

//--- rtl/adc_cmd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module adc_cmd_ctrl #(
	parameter int POWERUP_WAIT = 256 // Cycles before the first SPI write
) (
	input  logic               clk_in,
	input  logic               rst_in,
	input  logic               cmd_trig,
	input  logic [15:0]        cmd_addr,
	input  logic [15:0]        cmd_data,
	output logic               cmd_ready,
	output logic               spi_start,
	output adc_pkg::spi_word_t spi_word,
	input  logic               spi_ready
);
	import adc_pkg::*;

	localparam int WAIT_W = $clog2(POWERUP_WAIT + 1);
	localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(POWERUP_WAIT - 1);

	cmd_state_t        state;
	logic [WAIT_W-1:0] wait_cnt;   // Power-up countdown
	logic [1:0]        init_idx;   // Which init word is in flight
	logic              cmd_accept; // Host write seen in IDLE
	logic              spi_done;   // Engine back to idle after our start

	// Fixed power-up sequence
	function automatic spi_word_t init_word(input logic [1:0] idx);
		case (idx)
			2'd0:    init_word = INIT_RESET_WORD;
			2'd1:    init_word = INIT_FORMAT_WORD;
			default: init_word = INIT_LANES_WORD;
		endcase
	endfunction

	assign cmd_ready  = (state == IDLE);
	assign cmd_accept = cmd_ready && cmd_trig && (cmd_addr[15:8] == CMD_SET_REG);
	// Ready is still high in the cycle spi_start is out, so mask it
	assign spi_done   = spi_ready && !spi_start;

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state     <= WAIT_POWERUP;
			wait_cnt  <= WAIT_LAST;
			init_idx  <= '0;
			spi_start <= 1'b0;
		end else begin
			spi_start <= 1'b0; // Single cycle pulse by default
			case (state)
				WAIT_POWERUP: begin
					if (wait_cnt == '0)
						state <= INIT_LOAD;
					else
						wait_cnt <= wait_cnt - 1'b1;
				end

				INIT_LOAD: begin
					if (spi_ready) begin
						spi_start <= 1'b1;
						state     <= INIT_SEND;
					end
				end

				INIT_SEND: begin
					if (spi_done) begin
						if (init_idx == 2'd2) begin
							state <= IDLE; // Init complete, open to host
						end else begin
							init_idx <= init_idx + 2'd1;
							state    <= INIT_LOAD;
						end
					end
				end

				IDLE: begin
					if (cmd_accept)
						state <= SET_LOAD; // Other address bytes fall through
				end

				SET_LOAD: begin
					if (spi_ready) begin
						spi_start <= 1'b1;
						state     <= SET_SEND;
					end
				end

				SET_SEND: begin
					if (spi_done)
						state <= IDLE;
				end

				default: state <= IDLE;
			endcase
		end
	end

	// Outgoing SPI word, held steady across the transfer
	always_ff @(posedge clk_in) begin
		if (state == INIT_LOAD)
			spi_word <= init_word(init_idx);
		else if (cmd_accept)
			spi_word <= '{rw: 1'b0, addr: cmd_addr[6:0], data: cmd_data[7:0]};
	end

	// spi_done relies on the engine dropping ready right after the pulse
	a_start_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
		spi_start |=> !spi_start && !spi_ready)
		else $error("spi_start held for more than one cycle or not taken by SPI engine");

endmodule

`default_nettype wire

//--- rtl/lane_capture.sv
`timescale 1ns/10ps
`default_nettype none

module lane_capture (
	input  logic                                  clk_in,
	input  logic                                  rst_in,
	input  logic [adc_pkg::N_LANES-1:0]           lane_sdata,
	input  logic                                  bit_slip,
	output logic                                  word_valid,
	output logic [adc_pkg::LANE_BITS-1:0]         frame_word,
	output logic signed [adc_pkg::SAMPLE_BITS-1:0] adc_sample0,
	output logic signed [adc_pkg::SAMPLE_BITS-1:0] adc_sample1,
	output logic [adc_pkg::LANE_BITS-1:0]         frame_out,
	output logic                                  adc_valid
);
	import adc_pkg::*;

	localparam int FR_LANE = N_LANES - 1; // Frame lane is last
	localparam int CNT_W   = $clog2(LANE_BITS);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LANE_BITS - 1);

	logic [LANE_BITS-1:0] lane_sr [N_LANES]; // One shift register per lane
	logic [CNT_W-1:0]     bit_cnt;           // Position inside the word

	// Two lanes of one channel into a sample, lane a on odd bits
	function automatic logic [SAMPLE_BITS-1:0] interleave(
		input logic [LANE_BITS-1:0] lane_a,
		input logic [LANE_BITS-1:0] lane_b
	);
		logic [SAMPLE_BITS-1:0] s;
		s = '0;
		for (int k = 0; k < LANE_BITS; k++) begin
			s[SAMPLE_BITS-1-2*k] = lane_a[k];
			s[SAMPLE_BITS-2-2*k] = lane_b[k];
		end
		return s;
	endfunction

	////////////////////////////////////////
	// Serial to parallel
	////////////////////////////////////////

	// First bit of a word ends up in the MSB
	always_ff @(posedge clk_in) begin
		for (int i = 0; i < N_LANES; i++)
			lane_sr[i] <= {lane_sr[i][LANE_BITS-2:0], lane_sdata[i]};
	end

	assign frame_word = lane_sr[FR_LANE];

	// Slip holds the counter one cycle, boundary moves one bit
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			bit_cnt    <= '0;
			word_valid <= 1'b0;
		end else begin
			if (!bit_slip)
				bit_cnt <= bit_cnt + 1'b1; // Wraps after the eighth bit
			word_valid <= (bit_cnt == CNT_LAST) && !bit_slip;
		end
	end

	////////////////////////////////////////
	// Sample reassembly
	////////////////////////////////////////

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			adc_valid <= 1'b0;
		else
			adc_valid <= word_valid;
	end

	always_ff @(posedge clk_in) begin
		if (word_valid) begin
			adc_sample0 <= interleave(lane_sr[0], lane_sr[1]); // Channel 0
			adc_sample1 <= interleave(lane_sr[2], lane_sr[3]); // Channel 1
			frame_out   <= lane_sr[FR_LANE];
		end
	end

endmodule

`default_nettype wire

//--- rtl/frame_aligner.sv
`timescale 1ns/10ps
`default_nettype none

module frame_aligner #(
	parameter int SLIP_SETTLE = 3 // Frame words to let pass after a slip
) (
	input  logic                          clk_in,
	input  logic                          rst_in,
	input  logic                          word_valid,
	input  logic [adc_pkg::LANE_BITS-1:0] frame_word,
	output logic                          bit_slip,
	output logic                          frame_locked
);
	import adc_pkg::*;

	localparam int CNT_W = $clog2(SLIP_SETTLE + 2);
	localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(SLIP_SETTLE);

	align_state_t     state;
	logic [CNT_W-1:0] settle_cnt; // Mismatched words since last slip

	assign bit_slip = (state == SLIP); // SLIP lasts exactly one cycle

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state        <= CHECK;
			settle_cnt   <= '0;
			frame_locked <= 1'b0;
		end else begin
			case (state)
				CHECK: begin
					if (word_valid) begin
						if (frame_word == FRAME_PATTERN) begin
							frame_locked <= 1'b1; // Boundary found
							settle_cnt   <= '0;
						end else begin
							frame_locked <= 1'b0;
							// Give the previous slip time to take effect
							if (settle_cnt == SETTLE_LAST)
								state <= SLIP;
							else
								settle_cnt <= settle_cnt + 1'b1;
						end
					end
				end

				SLIP: begin
					settle_cnt <= '0;
					state      <= CHECK;
				end

				default: state <= CHECK;
			endcase
		end
	end

	// A frame word arriving during SLIP would go unchecked
	a_slip_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
		bit_slip |=> !bit_slip && !$past(word_valid))
		else $error("bit_slip longer than one cycle or frame word lost in slip");

endmodule

`default_nettype wire

//--- rtl/ltc2195_top.sv
`timescale 1ns/10ps
`default_nettype none

module ltc2195_top #(
	parameter int SPI_CLK_DIV  = 4,   // SCK half period in clk_in cycles
	parameter int POWERUP_WAIT = 256, // Delay before ADC configuration
	parameter int SLIP_SETTLE  = 3    // Words between bit slips
) (
	input  logic                                   clk_in,
	input  logic                                   rst_in,
	input  logic                                   cmd_trig,
	input  logic [15:0]                            cmd_addr,
	input  logic [15:0]                            cmd_data,
	output logic                                   cmd_ready,
	output logic                                   spi_scs,
	output logic                                   spi_sck,
	output logic                                   spi_sdo,
	input  logic [adc_pkg::N_LANES-1:0]            lane_sdata,
	output logic signed [adc_pkg::SAMPLE_BITS-1:0] adc_sample0,
	output logic signed [adc_pkg::SAMPLE_BITS-1:0] adc_sample1,
	output logic [adc_pkg::LANE_BITS-1:0]          frame_out,
	output logic                                   adc_valid,
	output logic                                   frame_locked
);
	import adc_pkg::*;

	////////////////////////////////////////
	// Configuration path
	////////////////////////////////////////

	logic      spi_start;
	spi_word_t spi_word;
	logic      spi_ready;

	adc_cmd_ctrl #(.POWERUP_WAIT(POWERUP_WAIT)) adc_cmd_ctrl_inst (
		.clk_in, .rst_in, .cmd_trig, .cmd_addr, .cmd_data, .cmd_ready,
		.spi_start, .spi_word, .spi_ready
	);

	spi_master #(.SPI_CLK_DIV(SPI_CLK_DIV)) spi_master_inst (
		.clk_in, .rst_in, .spi_start, .spi_word, .spi_ready,
		.spi_scs, .spi_sck, .spi_sdo
	);

	////////////////////////////////////////
	// Data path
	////////////////////////////////////////

	logic                 word_valid;
	logic [LANE_BITS-1:0] frame_word;
	logic                 bit_slip;

	lane_capture lane_capture_inst (
		.clk_in, .rst_in, .lane_sdata, .bit_slip, .word_valid, .frame_word,
		.adc_sample0, .adc_sample1, .frame_out, .adc_valid
	);

	frame_aligner #(.SLIP_SETTLE(SLIP_SETTLE)) frame_aligner_inst (
		.clk_in, .rst_in, .word_valid, .frame_word, .bit_slip, .frame_locked
	);

endmodule

`default_nettype wire

//--- test/tb_ltc2195.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ltc2195;
	import adc_pkg::*;

	localparam int SPI_CLK_DIV  = 4;
	localparam int POWERUP_WAIT = 256;
	localparam int SLIP_SETTLE  = 3;
	localparam int ALIGN_WORDS  = 8 * (SLIP_SETTLE + 2); // Worst case slip search
	localparam int PIPE_DELAY   = 10; // Word load to sample read, 8 bits plus 2 registers

	logic               clk_in;
	logic               rst_in;
	logic               cmd_trig;
	logic [15:0]        cmd_addr;
	logic [15:0]        cmd_data;
	logic               cmd_ready;
	logic               spi_scs;
	logic               spi_sck;
	logic               spi_sdo;
	logic [N_LANES-1:0] lane_sdata;
	logic signed [15:0] adc_sample0;
	logic signed [15:0] adc_sample1;
	logic [7:0]         frame_out;
	logic               adc_valid;
	logic               frame_locked;

	logic [15:0] init_q[$];     // Expected power-up words
	logic [15:0] cmd_addr_q[$];
	logic [15:0] cmd_data_q[$];
	logic [15:0] cmd_word_q[$]; // Zero means no frame
	logic [15:0] s0_q[$];
	logic [15:0] s1_q[$];
	logic [15:0] spi_exp_q[$];  // Frames still owed by the DUT
	int          due_q[$];      // Read cycle of each sample pair sent
	logic [7:0]  lane_w [4];    // Data lane words in flight
	int bit_idx, drv_cyc, chk_idx, next_smp, limit, cycle_cnt;
	int start_cnt, frame_cnt, spi_bits;
	logic        send_en, prev_scs, prev_sck, ready_seen;
	logic [15:0] spi_shift, exp_word;

	ltc2195_top #(
		.SPI_CLK_DIV(SPI_CLK_DIV), .POWERUP_WAIT(POWERUP_WAIT), .SLIP_SETTLE(SLIP_SETTLE)
	) ltc2195_top_inst (
		.clk_in, .rst_in, .cmd_trig, .cmd_addr, .cmd_data, .cmd_ready, .spi_scs, .spi_sck,
		.spi_sdo, .lane_sdata, .adc_sample0, .adc_sample1, .frame_out, .adc_valid,
		.frame_locked
	);

	initial begin
		clk_in = 1'b0;
		forever #4 clk_in = ~clk_in; // 8 ns period
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "check %s failed", name);
		end
	endtask

	// Lane word from one sample, odd picks the second lane of the channel
	function automatic logic [7:0] lane_word(input logic [15:0] s, input int odd);
		logic [7:0] w;
		for (int k = 0; k < 8; k++)
			w[k] = s[15-odd-2*k];
		return w;
	endfunction

	task automatic read_stimulus();
		byte         tag;
		int          fd, rc, ch;
		logic [15:0] a, b, c;
		fd = $fopen("test/ltc2195_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Stimulus file test/ltc2195_stimulus.txt could not be opened");
			$display("TEST RESULT: FAIL");
			$fatal(1, "no stimulus");
		end
		while ($fscanf(fd, " %c", tag) == 1) begin
			case (tag)
				"#": begin
					ch = $fgetc(fd); // Skip comment text
					while (ch != "\n" && ch != -1)
						ch = $fgetc(fd);
				end
				"I": begin
					rc = $fscanf(fd, "%h", a);
					check_value("stimulus_init_fields", 1, rc);
					init_q.push_back(a);
				end
				"C": begin
					rc = $fscanf(fd, "%h %h %h", a, b, c);
					check_value("stimulus_cmd_fields", 3, rc);
					cmd_addr_q.push_back(a);
					cmd_data_q.push_back(b);
					cmd_word_q.push_back(c);
				end
				"S": begin
					rc = $fscanf(fd, "%h %h", a, b);
					check_value("stimulus_sample_fields", 2, rc);
					s0_q.push_back(a);
					s1_q.push_back(b);
				end
				default: begin
					$display("Unknown record tag %c in the stimulus file", tag);
					$display("TEST RESULT: FAIL");
					$fatal(1, "bad stimulus record");
				end
			endcase
		end
		$fclose(fd);
	endtask

	// One host write, then wait for its frame or a quiet window
	task automatic run_command(input int idx);
		int starts;
		int frames;
		while (!cmd_ready)
			@(posedge clk_in);
		repeat ($urandom_range(5, 0)) @(posedge clk_in); // Idle gap
		if (cmd_word_q[idx] != 0)
			spi_exp_q.push_back(cmd_word_q[idx]);
		starts = start_cnt;
		frames = frame_cnt;
		cmd_trig <= 1'b1;
		cmd_addr <= cmd_addr_q[idx];
		cmd_data <= cmd_data_q[idx];
		@(posedge clk_in);
		cmd_trig <= 1'b0;
		if (cmd_word_q[idx] != 0) begin
			while (frame_cnt == frames)
				@(posedge clk_in);
			while (!cmd_ready)
				@(posedge clk_in);
			check_value($sformatf("cmd_%0d_frame_count", idx), starts + 1, start_cnt);
		end else begin
			repeat (2 * SPI_CLK_DIV + 4) begin
				@(posedge clk_in);
				check_value($sformatf("cmd_%0d_ready_kept", idx), 1, cmd_ready);
			end
			check_value($sformatf("cmd_%0d_no_frame", idx), starts, start_cnt);
		end
	endtask

	////////////////////////////////////////
	// SPI monitor, samples at clk_in edges
	////////////////////////////////////////

	always @(posedge clk_in) begin
		if (!rst_in) begin
			if (!spi_scs && prev_scs) begin // CS falling opens a frame
				spi_bits  = 0;
				start_cnt = start_cnt + 1;
			end
			if (spi_scs)
				check_value("spi_sck_idle", 0, spi_sck);
			if (spi_sck && !prev_sck) begin // Data valid at rising SCK
				check_value("spi_scs_low_in_frame", 0, spi_scs);
				spi_shift = {spi_shift[14:0], spi_sdo};
				spi_bits  = spi_bits + 1;
			end
			if (spi_scs && !prev_scs) begin
				check_value("spi_bit_count", 16, spi_bits);
				if (spi_exp_q.size() == 0) begin
					$display("Unexpected SPI frame %h with no write pending", spi_shift);
					$display("TEST RESULT: FAIL");
					$fatal(1, "extra SPI frame");
				end
				exp_word = spi_exp_q.pop_front();
				check_value($sformatf("spi_frame_%0d", frame_cnt), exp_word, spi_shift);
				frame_cnt = frame_cnt + 1;
			end
			if (cmd_ready && !ready_seen) begin // Host port opens after init only
				check_value("frames_before_cmd_ready", 3, frame_cnt);
				ready_seen = 1'b1;
			end
		end
		prev_scs = spi_scs;
		prev_sck = spi_sck;
	end

	////////////////////////////////////////
	// Lane driver and sample checker
	////////////////////////////////////////

	always @(posedge clk_in) begin
		drv_cyc = drv_cyc + 1;
		if (chk_idx < due_q.size() && due_q[chk_idx] == drv_cyc) begin
			check_value($sformatf("adc_valid_%0d", chk_idx), 1, adc_valid);
			check_value($sformatf("adc_sample0_%0d", chk_idx), s0_q[chk_idx],
				$unsigned(adc_sample0));
			check_value($sformatf("adc_sample1_%0d", chk_idx), s1_q[chk_idx],
				$unsigned(adc_sample1));
			check_value($sformatf("frame_out_%0d", chk_idx), FRAME_PATTERN, frame_out);
			chk_idx = chk_idx + 1;
		end
		if (bit_idx == 7) begin // Word boundary on the frame lane
			foreach (lane_w[i])
				lane_w[i] = '0;
			next_smp = due_q.size();
			if (send_en && next_smp < s0_q.size()) begin
				lane_w[0] = lane_word(s0_q[next_smp], 0);
				lane_w[1] = lane_word(s0_q[next_smp], 1);
				lane_w[2] = lane_word(s1_q[next_smp], 0);
				lane_w[3] = lane_word(s1_q[next_smp], 1);
				due_q.push_back(drv_cyc + PIPE_DELAY);
			end
		end
		lane_sdata <= {FRAME_PATTERN[bit_idx], lane_w[3][bit_idx], lane_w[2][bit_idx],
			lane_w[1][bit_idx], lane_w[0][bit_idx]}; // MSB first on every lane
		bit_idx = (bit_idx == 0) ? 7 : bit_idx - 1;
	end

	always @(posedge clk_in) begin
		cycle_cnt = cycle_cnt + 1;
		if (limit > 0 && cycle_cnt >= limit) begin
			$display("Run timed out after %0d cycles", cycle_cnt);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	initial begin
		rst_in     = 1'b1;
		cmd_trig   = 1'b0;
		cmd_addr   = '0;
		cmd_data   = '0;
		lane_sdata = '0;
		send_en    = 1'b0;
		prev_scs   = 1'b1;
		prev_sck   = 1'b0;
		ready_seen = 1'b0;
		spi_shift  = '0;
		foreach (lane_w[i])
			lane_w[i] = '0;
		{drv_cyc, chk_idx, cycle_cnt, start_cnt, frame_cnt, spi_bits} = '0;
		void'($urandom(32'h81d0));
		bit_idx = $urandom_range(7, 0); // Random start phase of the lanes
		read_stimulus();
		limit = 2 * (POWERUP_WAIT + 40 * SPI_CLK_DIV * (init_q.size() + cmd_word_q.size())
			+ 16 * (s0_q.size() + ALIGN_WORDS));
		foreach (init_q[i])
			spi_exp_q.push_back(init_q[i]);
		repeat (2) @(posedge clk_in);
		check_value("reset_spi_scs", 1, spi_scs);
		check_value("reset_spi_sck", 0, spi_sck);
		check_value("reset_spi_sdo", 0, spi_sdo);
		check_value("reset_cmd_ready", 0, cmd_ready);
		check_value("reset_adc_valid", 0, adc_valid);
		check_value("reset_frame_locked", 0, frame_locked);
		rst_in <= 1'b0;
		foreach (cmd_word_q[i])
			run_command(i);
		while (!frame_locked)
			@(posedge clk_in);
		check_value("frame_out_at_lock", FRAME_PATTERN, frame_out);
		send_en <= 1'b1; // Samples start at the next word boundary
		while (chk_idx < s0_q.size())
			@(posedge clk_in);
		check_value("spi_frames_missing", 0, spi_exp_q.size());
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/ltc2195_stimulus.txt
# I word : expected power-up SPI word, in order
# C addr data word : host write and its SPI word, word 0000 means no frame
# S sample0 sample1 : signed sample pair sent after frame lock
I 0080
I 0120
I 0200
C 3105 00a5 05a5
C 3214 0033 0000
C 317f 12ff 7fff
C 0031 0044 0000
C 3185 ff3c 053c
S 1234 5678
S 8000 7fff
S ffff 0001
S a5c3 3c5a
S 0000 fedc

//--- verilog.f
rtl/adc_pkg.sv
rtl/spi_master.sv
rtl/adc_cmd_ctrl.sv
rtl/lane_capture.sv
rtl/frame_aligner.sv
rtl/ltc2195_top.sv
test/tb_ltc2195.sv
